// ==== hdl/mul_pkg.sv ====
package mul_pkg;

	// --------------------
	// Widths
	// --------------------

	// Register width of the core that this multiply unit serves
	localparam int xlen = 32;

	// --------------------
	// Opcodes
	// --------------------

	// The four M-extension multiply operations
	// Only op_mul returns the low half of the product
	// The other three return the high half and differ in operand signedness
	typedef enum logic [1:0] {
		op_mul    = 2'd0,
		op_mulh   = 2'd1,
		op_mulhsu = 2'd2,
		op_mulhu  = 2'd3
	} mul_op_e;

	// --------------------
	// Transfer types
	// --------------------

	// One multiply request as it enters the unit and as it is issued to a lane
	// The opcode sits in the top two bits, followed by a and then b
	typedef struct packed {
		mul_op_e         op;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
	} mul_req_t;

	// One multiply result as it leaves a lane and the unit
	typedef struct packed {
		logic [xlen-1:0] result;
	} mul_rsp_t;

endpackage

// ==== hdl/mul_lane.sv ====
`timescale 1ns/1ns

module mul_lane (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  mul_pkg::mul_req_t issue_req,
	output logic              lane_valid,
	output mul_pkg::mul_rsp_t lane_rsp
);
	import mul_pkg::*;

	// Operand and opcode registers, loaded on the issue edge
	mul_op_e           op_q;
	logic [xlen-1:0]   a_q;
	logic [xlen-1:0]   b_q;

	// Progress of the operation through the lane
	logic [1:0]        stage;

	// Extended operands and the full double-width product
	logic              a_signed;
	logic              b_signed;
	logic [2*xlen-1:0] a_ext;
	logic [2*xlen-1:0] b_ext;
	logic [2*xlen-1:0] product;

	// --------------------
	// Operand capture
	// --------------------

	// The dispatcher never issues to this lane again before the result edge,
	// so these hold steady for the whole two-cycle product path
	always_ff @(posedge clk) begin
		if (issue) begin
			op_q <= issue_req.op;
			a_q  <= issue_req.a;
			b_q  <= issue_req.b;
		end
	end

	// --------------------
	// Product
	// --------------------

	// MULH treats both operands as signed, MULHSU only a, MULHU and MUL neither
	// MUL ignores signedness anyway since only the low half is kept
	always_comb begin
		a_signed = (op_q == op_mulh) || (op_q == op_mulhsu);
		b_signed = (op_q == op_mulh);
		a_ext    = {{xlen{a_q[xlen-1] & a_signed}}, a_q};
		b_ext    = {{xlen{b_q[xlen-1] & b_signed}}, b_q};
		product  = a_ext * b_ext;
	end

	// Result half is picked by the opcode and captured two edges after issue
	// That edge is also the earliest one at which the next issue can land
	always_ff @(posedge clk) begin
		if (stage[1]) begin
			lane_rsp.result <= (op_q == op_mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];
		end
	end

	// --------------------
	// Valid pipeline
	// --------------------

	// stage[0] marks operands loaded, stage[1] marks the product settling
	// lane_valid follows stage[1] by one edge to line up with the result register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage      <= 2'b00;
			lane_valid <= 1'b0;
		end else begin
			stage      <= {stage[0], issue};
			lane_valid <= stage[1];
		end
	end

endmodule

// ==== hdl/mul_dispatch.sv ====
`timescale 1ns/1ns

module mul_dispatch #(
	parameter int n_lanes   = 2,
	parameter int in_depth  = 4,
	parameter int rsp_depth = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               req_valid,
	input  mul_pkg::mul_req_t  req,
	output logic               req_credit,
	output logic [n_lanes-1:0] issue,
	output mul_pkg::mul_req_t  issue_req,
	input  logic               slot_free
);
	import mul_pkg::*;

	localparam int ptr_w  = (in_depth > 1) ? $clog2(in_depth) : 1;
	localparam int cnt_w  = $clog2(in_depth + 1);
	localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1;
	localparam int slot_w = $clog2(rsp_depth + 1);

	// Input request queue
	mul_req_t           q_mem [in_depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [cnt_w-1:0]   q_count;

	// Lane tracking
	logic [lane_w-1:0]  rr_ptr;
	logic [1:0]         busy_cnt [n_lanes];
	logic [n_lanes-1:0] lane_free;

	// Free entries in the collector queue not yet claimed by an issued request
	logic [slot_w-1:0]  slot_cnt;

	// Head of the queue goes to a lane this cycle
	logic               fire;

	// --------------------
	// Issue decision
	// --------------------

	// Busy count is 2 right after issue and the lane takes a new operation at the
	// edge where the count falls from 1 to 0, giving an issue interval of two
	always_comb begin
		for (int i = 0; i < n_lanes; i++) begin
			lane_free[i] = (busy_cnt[i] <= 2'd1);
		end
	end

	assign fire      = (q_count != '0) && lane_free[rr_ptr] && (slot_cnt != '0);
	assign issue     = fire ? (n_lanes'(1) << rr_ptr) : '0;
	assign issue_req = q_mem[rd_ptr];

	// --------------------
	// Request queue
	// --------------------

	// The upstream only sends while it holds a credit, so a push never meets a full queue
	always_ff @(posedge clk) begin
		if (req_valid) begin
			q_mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			req_credit <= 1'b0;
		end else begin
			if (req_valid) begin
				wr_ptr <= (wr_ptr == ptr_w'(in_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (fire) begin
				rd_ptr <= (rd_ptr == ptr_w'(in_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count unchanged
			case ({req_valid, fire})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
			// Each departing request frees one queue slot for the upstream
			req_credit <= fire;
		end
	end

	// --------------------
	// Lane and slot state
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr   <= '0;
			slot_cnt <= slot_w'(rsp_depth);
			for (int i = 0; i < n_lanes; i++) begin
				busy_cnt[i] <= 2'd0;
			end
		end else begin
			// Issue order 0, 1, .. n_lanes-1, matched by the collector
			if (fire) begin
				rr_ptr <= (rr_ptr == lane_w'(n_lanes - 1)) ? '0 : rr_ptr + 1'b1;
			end
			for (int i = 0; i < n_lanes; i++) begin
				if (issue[i]) begin
					busy_cnt[i] <= 2'd2;
				end else if (busy_cnt[i] != 2'd0) begin
					busy_cnt[i] <= busy_cnt[i] - 2'd1;
				end
			end
			// A slot is claimed at issue and given back when the collector emits it
			case ({fire, slot_free})
				2'b10:   slot_cnt <= slot_cnt - 1'b1;
				2'b01:   slot_cnt <= slot_cnt + 1'b1;
				default: slot_cnt <= slot_cnt;
			endcase
		end
	end

endmodule

// ==== hdl/mul_collect.sv ====
`timescale 1ns/1ns

module mul_collect #(
	parameter int n_lanes     = 2,
	parameter int rsp_depth   = 4,
	parameter int out_credits = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [n_lanes-1:0] lane_valid,
	input  mul_pkg::mul_rsp_t  lane_rsp [n_lanes],
	output logic               slot_free,
	output logic               rsp_valid,
	output mul_pkg::mul_rsp_t  rsp,
	input  logic               rsp_credit
);
	import mul_pkg::*;

	localparam int ptr_w  = (rsp_depth > 1) ? $clog2(rsp_depth) : 1;
	localparam int cnt_w  = $clog2(rsp_depth + 1);
	localparam int lane_w = (n_lanes > 1) ? $clog2(n_lanes) : 1;
	localparam int cred_w = $clog2(out_credits + 1);

	// In-order response queue
	mul_rsp_t          q_mem [rsp_depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  q_count;

	// Lane whose result is due next
	logic [lane_w-1:0] rr_ptr;
	logic              take;

	// Credits held for the downstream consumer
	logic [cred_w-1:0] out_cnt;

	// --------------------
	// Result gathering
	// --------------------

	// All lanes share one latency and were issued in round-robin order,
	// so the pointed lane is always the next to finish
	assign take = lane_valid[rr_ptr];

	// Slot credits held by the dispatcher keep this write from overflowing the queue
	always_ff @(posedge clk) begin
		if (take) begin
			q_mem[wr_ptr] <= lane_rsp[rr_ptr];
		end
	end

	// --------------------
	// Response output
	// --------------------

	// Head is shown whenever there is one and the consumer has room for it
	assign rsp_valid = (q_count != '0) && (out_cnt != '0);
	assign rsp       = q_mem[rd_ptr];

	// Every presented entry is popped at once and its slot handed back upstream
	assign slot_free = rsp_valid;

	// --------------------
	// Pointers and counters
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr  <= '0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
			out_cnt <= cred_w'(out_credits);
		end else begin
			if (take) begin
				rr_ptr <= (rr_ptr == lane_w'(n_lanes - 1)) ? '0 : rr_ptr + 1'b1;
				wr_ptr <= (wr_ptr == ptr_w'(rsp_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rsp_valid) begin
				rd_ptr <= (rd_ptr == ptr_w'(rsp_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({take, rsp_valid})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
			// One credit spent per response, one returned per rsp_credit pulse
			case ({rsp_valid, rsp_credit})
				2'b10:   out_cnt <= out_cnt - 1'b1;
				2'b01:   out_cnt <= out_cnt + 1'b1;
				default: out_cnt <= out_cnt;
			endcase
		end
	end

endmodule

// ==== hdl/mul_array_top.sv ====
`timescale 1ns/1ns

module mul_array_top #(
	parameter int n_lanes     = 2,
	parameter int in_depth    = 4,
	parameter int rsp_depth   = 4,
	parameter int out_credits = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  mul_pkg::mul_req_t req,
	output logic              req_credit,
	output logic              rsp_valid,
	output mul_pkg::mul_rsp_t rsp,
	input  logic              rsp_credit
);
	import mul_pkg::*;

	// --------------------
	// Internal links
	// --------------------

	// Dispatcher to lanes, one issue strobe per lane and a shared request bus
	logic [n_lanes-1:0] issue;
	mul_req_t           issue_req;

	// Lanes to collector
	logic [n_lanes-1:0] lane_valid;
	mul_rsp_t           lane_rsp [n_lanes];

	// Collector back to dispatcher, one pulse per freed queue slot
	logic               slot_free;

	// Requests are queued and dealt to lanes round-robin
	mul_dispatch #(
		.n_lanes   (n_lanes),
		.in_depth  (in_depth),
		.rsp_depth (rsp_depth)
	) u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.issue      (issue),
		.issue_req  (issue_req),
		.slot_free  (slot_free)
	);

	// Identical multiplier lanes, each with a two-cycle issue interval
	for (genvar i = 0; i < n_lanes; i++) begin : lane
		mul_lane u_lane (
			.clk        (clk),
			.rst_n      (rst_n),
			.issue      (issue[i]),
			.issue_req  (issue_req),
			.lane_valid (lane_valid[i]),
			.lane_rsp   (lane_rsp[i])
		);
	end

	// Results are gathered in issue order and sent out under credit
	mul_collect #(
		.n_lanes     (n_lanes),
		.rsp_depth   (rsp_depth),
		.out_credits (out_credits)
	) u_collect (
		.clk        (clk),
		.rst_n      (rst_n),
		.lane_valid (lane_valid),
		.lane_rsp   (lane_rsp),
		.slot_free  (slot_free),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

endmodule

// ==== verification/mul_array_props.sv ====
`timescale 1ns/1ns

module mul_array_props #(
	parameter int n_lanes     = 2,
	parameter int rsp_depth   = 4,
	parameter int out_credits = 2
) (
	input logic                               clk,
	input logic                               rst_n,
	input logic [n_lanes-1:0]                 issue,
	input logic [$clog2(rsp_depth + 1)-1:0]   slot_cnt,
	input logic [$clog2(out_credits + 1)-1:0] out_cnt,
	input logic                               rsp_valid,
	input logic                               rsp_credit
);

	// Number of property failures, read by the testbench at the end of the run
	int unsigned violations = 0;

	// Consumer credits as seen on the response interface alone
	int          iface_credits;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iface_credits <= out_credits;
		end else begin
			iface_credits <= iface_credits - int'(rsp_valid) + int'(rsp_credit);
		end
	end

	// --------------------
	// Dispatcher side
	// --------------------

	// Slot credits come back only for entries that were claimed, so the count stays bounded
	slot_bound: assert property (@(posedge clk) disable iff (!rst_n)
		slot_cnt <= rsp_depth)
	else begin
		violations++;
		$error("Slot credit count rose above the collector queue depth");
	end

	// A lane issued in the previous cycle is still working on its product
	// and must not get a new operation
	issue_free: assert property (@(posedge clk) disable iff (!rst_n)
		(issue & $past(issue)) == '0)
	else begin
		violations++;
		$error("An issue strobe went to a lane that was still busy");
	end

	// The shared issue bus serves one lane per cycle
	issue_single: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(issue))
	else begin
		violations++;
		$error("More than one issue strobe was high in the same cycle");
	end

	// --------------------
	// Collector side
	// --------------------

	out_bound: assert property (@(posedge clk) disable iff (!rst_n)
		out_cnt <= out_credits)
	else begin
		violations++;
		$error("Output credit count rose above the consumer's credit allowance");
	end

	// A response without a credit would overrun the consumer
	valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
		!(rsp_valid && (iface_credits == 0)))
	else begin
		violations++;
		$error("rsp_valid was high while no output credit was held");
	end

endmodule

// Each copy watches one block and holds the inputs of the other block idle
bind mul_dispatch mul_array_props #(
	.n_lanes     (n_lanes),
	.rsp_depth   (rsp_depth),
	.out_credits (1)
) props (
	.clk        (clk),
	.rst_n      (rst_n),
	.issue      (issue),
	.slot_cnt   (slot_cnt),
	.out_cnt    ('0),
	.rsp_valid  (1'b0),
	.rsp_credit (1'b0)
);

bind mul_collect mul_array_props #(
	.n_lanes     (n_lanes),
	.rsp_depth   (rsp_depth),
	.out_credits (out_credits)
) props (
	.clk        (clk),
	.rst_n      (rst_n),
	.issue      ('0),
	.slot_cnt   ('0),
	.out_cnt    (out_cnt),
	.rsp_valid  (rsp_valid),
	.rsp_credit (rsp_credit)
);

// ==== verification/mul_array_tb.sv ====
`timescale 1ns/1ns

module mul_array_tb;
	import mul_pkg::*;

	// Same numbers as the defaults of the unit
	localparam int n_lanes     = 2;
	localparam int in_depth    = 4;
	localparam int rsp_depth   = 4;
	localparam int out_credits = 2;

	localparam int phase1_reqs    = 1500;
	localparam int phase2_reqs    = 300;
	localparam int hold_cycles    = 200;
	localparam int total_reqs     = phase1_reqs + phase2_reqs;
	localparam int timeout_cycles = 20 * total_reqs;

	logic     clk;
	logic     rst_n;
	logic     req_valid;
	mul_req_t req;
	logic     req_credit;
	logic     rsp_valid;
	mul_rsp_t rsp;
	logic     rsp_credit;

	logic [31:0] rng_state = 32'hcfbd_729f;

	// Requests in send order and their model results
	mul_req_t    sent_q [$];
	logic [31:0] exp_q [$];

	int up_credits;
	int credit_pulses;
	int sent_count;
	int send_limit;
	int rsp_count;
	int credits_owed;
	int return_delay;
	int neg_cycle;
	int clk_cycles;
	int first_send_cycle;
	int first_rsp_cycle;
	int value_errors;
	int proto_errors;
	bit hold_credits;

	mul_array_top #(
		.n_lanes     (n_lanes),
		.in_depth    (in_depth),
		.rsp_depth   (rsp_depth),
		.out_credits (out_credits)
	) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) clk_cycles <= clk_cycles + 1;

	// --------------------
	// Random numbers and model
	// --------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// One operand in four is a corner value, the rest are uniform
	function automatic logic [31:0] pick_operand();
		logic [31:0] r;
		logic [31:0] value;
		r = next_rand();
		if (r[1:0] != 2'd0) begin
			value = next_rand();
		end else begin
			case (r[3:2])
				2'd0:    value = 32'h0000_0000;
				2'd1:    value = 32'h0000_0001;
				2'd2:    value = 32'hffff_ffff;
				default: value = 32'h8000_0000;
			endcase
		end
		return value;
	endfunction

	// 64-bit arithmetic on sign- or zero-extended values gives the exact product
	function automatic logic [31:0] model_result(input mul_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		longint      a_s;
		longint      a_u;
		longint      b_s;
		longint      b_u;
		logic [63:0] p;
		a_s = longint'(signed'(a));
		a_u = longint'(a);
		b_s = longint'(signed'(b));
		b_u = longint'(b);
		case (op)
			op_mulh:   p = a_s * b_s;
			op_mulhsu: p = a_s * b_u;
			default:   p = a_u * b_u;
		endcase
		return (op == op_mul) ? p[31:0] : p[63:32];
	endfunction

	// --------------------
	// Per-cycle tasks
	// --------------------

	// Outputs come from registers, so they are steady at the falling edge
	task automatic observe_outputs();
		mul_req_t    sent_req;
		logic [31:0] expected;
		if (req_credit) begin
			up_credits++;
			credit_pulses++;
			assert (up_credits <= in_depth) else begin
				proto_errors++;
				$display("More request credits came back than were spent at %0t", $time);
			end
		end
		if (rsp_valid) begin
			rsp_count++;
			credits_owed++;
			// Sent at cycle n, accepted at the next edge, visible 4 edges later
			if (first_rsp_cycle < 0) begin
				first_rsp_cycle = neg_cycle;
				assert (first_rsp_cycle - first_send_cycle >= 5) else begin
					proto_errors++;
					$display("First response came sooner than 4 cycles after its request");
				end
			end
			assert (exp_q.size() != 0) else begin
				proto_errors++;
				$display("A response arrived with no request outstanding at %0t", $time);
			end
			if (exp_q.size() != 0) begin
				sent_req = sent_q.pop_front();
				expected = exp_q.pop_front();
				assert (rsp.result == expected) else begin
					value_errors++;
					$display("Fail at %0t: %s a=%h b=%h gave %h, expected %h", $time,
						sent_req.op.name(), sent_req.a, sent_req.b, rsp.result, expected);
				end
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		mul_req_t    new_req;
		r = next_rand();
		// Consumer hands each credit back after a random delay of 0 to 3 cycles
		rsp_credit = 1'b0;
		if (!hold_credits && credits_owed > 0) begin
			if (return_delay == 0) begin
				rsp_credit = 1'b1;
				credits_owed--;
				return_delay = int'(r[9:8]);
			end else begin
				return_delay--;
			end
		end
		// Upstream sends with a chance of 6 in 8 while it holds a credit
		if (sent_count < send_limit && up_credits > 0 && r[2:0] < 3'd6) begin
			new_req.op = mul_op_e'(r[5:4]);
			new_req.a  = pick_operand();
			new_req.b  = pick_operand();
			req_valid  = 1'b1;
			req        = new_req;
			up_credits--;
			sent_count++;
			sent_q.push_back(new_req);
			exp_q.push_back(model_result(new_req.op, new_req.a, new_req.b));
			if (first_send_cycle < 0) begin
				first_send_cycle = neg_cycle;
			end
		end else begin
			req_valid = 1'b0;
			req       = '0;
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);
		neg_cycle++;
		observe_outputs();
		drive_inputs();
	endtask

	// --------------------
	// Watchdog
	// --------------------

	initial begin
		wait (clk_cycles >= timeout_cycles);
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		int          held_rsp;
		int          late_credits;
		int unsigned prop_violations;
		rst_n            = 1'b0;
		req_valid        = 1'b0;
		req              = '0;
		rsp_credit       = 1'b0;
		up_credits       = in_depth;
		first_send_cycle = -1;
		first_rsp_cycle  = -1;
		hold_credits     = 1'b0;
		send_limit       = 0;
		held_rsp         = 0;
		late_credits     = 0;

		repeat (4) begin
			@(negedge clk);
			assert (!req_credit && !rsp_valid) else begin
				proto_errors++;
				$display("req_credit or rsp_valid was high during reset at %0t", $time);
			end
		end
		rst_n = 1'b1;

		// Nothing may come out while no request has been sent
		repeat (4) begin
			run_cycle();
			assert (!req_credit && !rsp_valid) else begin
				proto_errors++;
				$display("req_credit or rsp_valid was high right after reset at %0t", $time);
			end
		end

		// Free-running credits
		send_limit = phase1_reqs;
		while (sent_count < send_limit) run_cycle();

		// Consumer withholds its credits so the back-pressure reaches the upstream
		send_limit   = total_reqs;
		hold_credits = 1'b1;
		for (int i = 0; i < hold_cycles; i++) begin
			run_cycle();
			if (rsp_valid) held_rsp++;
			if (req_credit && i >= hold_cycles / 2) late_credits++;
		end
		assert (held_rsp <= out_credits) else begin
			proto_errors++;
			$display("%0d responses came out while credits were withheld", held_rsp);
		end
		assert (late_credits == 0) else begin
			proto_errors++;
			$display("req_credit kept pulsing after the queues should have filled");
		end
		assert (up_credits == 0) else begin
			proto_errors++;
			$display("Upstream still held %0d credits under back-pressure", up_credits);
		end
		hold_credits = 1'b0;
		while (sent_count < send_limit) run_cycle();

		// Drain
		while (exp_q.size() != 0 || credits_owed != 0) run_cycle();
		repeat (20) run_cycle();

		assert (rsp_count == sent_count && exp_q.size() == 0) else begin
			proto_errors++;
			$display("Got %0d responses for %0d requests", rsp_count, sent_count);
		end
		assert (up_credits == in_depth && credit_pulses == sent_count) else begin
			proto_errors++;
			$display("Request credits not conserved, %0d held and %0d returned",
				up_credits, credit_pulses);
		end

		prop_violations = DUT.u_dispatch.props.violations + DUT.u_collect.props.violations;
		$display("Errors: %0d wrong values, %0d protocol, %0d property; %0d responses to %0d %s",
			value_errors, proto_errors, prop_violations, rsp_count, sent_count, "requests");
		if (value_errors == 0 && proto_errors == 0 && prop_violations == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/mul_pkg.sv
hdl/mul_lane.sv
hdl/mul_dispatch.sv
hdl/mul_collect.sv
hdl/mul_array_top.sv
verification/mul_array_props.sv
verification/mul_array_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -j 0 \
	--top-module mul_array_tb \
	-f filelist.f \
	--Mdir obj_dir \
	-o Vmul_array_tb

./obj_dir/Vmul_array_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"
